/* hdl/readout_pkg.sv */
package readout_pkg;

  // Datapath sizes
  localparam int sample_w     = 16;
  localparam int row_w        = 6;
  localparam int col_w        = 4;
  localparam int word_w       = 32;
  localparam int frame_num_w  = 12;  // Frame number and word count in trailer
  localparam int fifo_depth   = 64;
  localparam int fifo_addr_w  = $clog2(fifo_depth);
  localparam int fifo_level_w = 7;   // Holds 0..fifo_depth
  localparam int veto_hold    = 450; // Settling time after reset, in clk100M cycles
  localparam int veto_cnt_w   = $clog2(veto_hold + 1);

  // APB register map, byte addresses
  localparam logic [3:0] addr_control = 4'h0;
  localparam logic [3:0] addr_window  = 4'h4;
  localparam logic [3:0] addr_status  = 4'h8;
  localparam logic [3:0] addr_chip    = 4'hC;

  // Bits of the control register
  localparam int ctl_init     = 0;
  localparam int ctl_start    = 1;
  localparam int ctl_stop     = 2;
  localparam int ctl_soft_rst = 3;

  localparam logic [7:0] trailer_tag = 8'hFE;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [3:0]        paddr;
    logic [word_w-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [word_w-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic                valid;
    logic [row_w-1:0]    row;
    logic [col_w-1:0]    col;
    logic [sample_w-1:0] sample;
    logic                frame_last; // Last sample of the frame
  } adc_sample_t;

  // Inclusive bounds, also the layout of the window register
  typedef struct packed {
    logic [row_w-1:0] row_start;
    logic [row_w-1:0] row_end;
    logic [col_w-1:0] col_start;
    logic [col_w-1:0] col_end;
  } read_window_t;

  typedef struct packed {
    logic init;
    logic start;
    logic stop;
    logic soft_rst;
  } run_cmd_t;

  typedef enum logic [1:0] {
    st_idle     = 2'd0,
    st_armed    = 2'd1,
    st_running  = 2'd2,
    st_draining = 2'd3
  } run_state_e;

  // Low bits of the status register
  typedef struct packed {
    run_state_e              state;
    logic                    veto;
    logic                    fifo_full;
    logic [fifo_level_w-1:0] fifo_level;
  } run_status_t;

  // One FIFO word, read as a pixel pair or as a frame trailer
  typedef union packed {
    struct packed {
      logic [sample_w-1:0] second; // High half, zero on a flushed half word
      logic [sample_w-1:0] first;
    } pixels;
    struct packed {
      logic [7:0]             tag;
      logic [frame_num_w-1:0] frame_number;
      logic [frame_num_w-1:0] word_count;   // Data words in the frame
    } trailer;
  } readout_word_u;

  typedef struct packed {
    logic          is_trailer; // Selects the union view
    readout_word_u word;
  } fifo_entry_t;

endpackage

/* hdl/cmd_regs.sv */
`timescale 1ns/1ps

module cmd_regs (
  input  logic                      clk100M,
  input  logic                      rst_command,
  input  readout_pkg::apb_req_t     apb_req,
  output readout_pkg::apb_rsp_t     apb_rsp,
  input  readout_pkg::run_status_t  status,
  output readout_pkg::run_cmd_t     cmd,
  output readout_pkg::read_window_t window,
  output logic [7:0]                chip_addr
);
  import readout_pkg::*;

  logic        wr_access;  // Last cycle of an APB write
  logic        addr_hit;   // Mapped register
  logic [7:0]  chip_reg;   // Written by software, sent on init
  run_status_t status_q;   // Snapshot for readback

  assign wr_access = apb_req.psel & apb_req.penable & apb_req.pwrite;

  // Address decode and read mux
  always_comb begin
    addr_hit       = 1'b1;
    apb_rsp.prdata = '0;
    case (apb_req.paddr)
      addr_control: apb_rsp.prdata = '0; // Commands are pulses, read as zero
      addr_window:  apb_rsp.prdata = word_w'(window);
      addr_status:  apb_rsp.prdata = word_w'(status_q);
      addr_chip:    apb_rsp.prdata = word_w'(chip_reg);
      default:      addr_hit = 1'b0;
    endcase
    apb_rsp.pready  = 1'b1;                   // No wait states
    apb_rsp.pslverr = apb_req.psel & ~addr_hit;
  end

  // Command pulses, one cycle after the control write
  always_ff @(posedge clk100M) begin
    if (rst_command) begin
      cmd <= '0;
    end else begin
      cmd <= '0;
      if (wr_access && apb_req.paddr == addr_control) begin
        cmd.init     <= apb_req.pwdata[ctl_init];
        cmd.start    <= apb_req.pwdata[ctl_start];
        cmd.stop     <= apb_req.pwdata[ctl_stop];
        cmd.soft_rst <= apb_req.pwdata[ctl_soft_rst];
      end
    end
  end

  // Window and chip address registers
  always_ff @(posedge clk100M) begin
    if (rst_command) begin
      window.row_start <= '0;   // Whole sensor by default
      window.row_end   <= '1;
      window.col_start <= '0;
      window.col_end   <= '1;
      chip_reg         <= '0;
      chip_addr        <= '0;
    end else begin
      if (wr_access && apb_req.paddr == addr_window) begin
        window <= apb_req.pwdata[$bits(read_window_t)-1:0];
      end
      if (wr_access && apb_req.paddr == addr_chip) begin
        chip_reg <= apb_req.pwdata[7:0];
      end
      if (cmd.init) begin
        chip_addr <= chip_reg;  // Chip only sees a new address on init
      end
    end
  end

  // Status sampled once per cycle
  always_ff @(posedge clk100M) begin
    status_q <= status;
  end

endmodule

/* hdl/run_control.sv */
`timescale 1ns/1ps

module run_control (
  input  logic                    clk100M,
  input  logic                    rst_command,
  input  readout_pkg::run_cmd_t   cmd,
  input  logic                    frame_done,
  input  logic                    fifo_full,
  output logic                    capture_en,
  output logic                    frame_rst,
  output logic                    fifo_clear,
  output readout_pkg::run_state_e state,
  output logic                    veto
);
  import readout_pkg::*;

  logic [veto_cnt_w-1:0] hold_cnt;    // Cycles since the last reset
  logic                  hold_active; // Still settling
  logic                  ovf_veto;    // Latched FIFO overflow

  assign hold_active = hold_cnt != veto_cnt_w'(veto_hold);
  assign veto        = hold_active | ovf_veto;

  // Capture only while a run is live and nothing blocks writes
  assign capture_en = (state == st_running || state == st_draining) && !veto;

  assign frame_rst  = cmd.init | cmd.soft_rst; // New run numbering starts at 0
  assign fifo_clear = cmd.soft_rst;

  // Run FSM
  always_ff @(posedge clk100M) begin
    if (rst_command || cmd.soft_rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (cmd.init) state <= st_armed;
        end
        st_armed: begin
          if (cmd.start) state <= st_running;
        end
        st_running: begin
          if (cmd.stop) state <= st_draining;
        end
        st_draining: begin
          if (frame_done) state <= st_idle; // Frame in flight is finished
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Settling counter and overflow latch
  always_ff @(posedge clk100M) begin
    if (rst_command || cmd.soft_rst) begin
      hold_cnt <= '0;
      ovf_veto <= 1'b0;
    end else begin
      if (hold_active) begin
        hold_cnt <= hold_cnt + 1'b1;  // Stops at veto_hold
      end
      if (fifo_full) begin
        ovf_veto <= 1'b1;             // Stays until the next reset
      end
    end
  end

endmodule

/* hdl/pixel_packer.sv */
`timescale 1ns/1ps

module pixel_packer (
  input  logic                      clk100M,
  input  logic                      rst_command,
  input  logic                      frame_rst,
  input  logic                      capture_en,
  input  readout_pkg::adc_sample_t  sample,
  input  readout_pkg::read_window_t window,
  output logic                      wr_en,
  output readout_pkg::fifo_entry_t  entry,
  output logic                      frame_done
);
  import readout_pkg::*;

  logic                   in_window;
  logic                   keep;         // Sample goes into a word
  logic                   last;         // Frame end seen while capturing
  logic                   trailer_now;
  logic [sample_w-1:0]    held;         // First half of a pair
  logic                   pending;
  logic                   trailer_pend; // Trailer after a final data word
  logic [frame_num_w-1:0] word_cnt;
  logic [frame_num_w-1:0] frame_num;
  readout_word_u          trailer_word;

  // Inclusive bounds on both axes
  assign in_window = sample.row >= window.row_start && sample.row <= window.row_end &&
                     sample.col >= window.col_start && sample.col <= window.col_end;

  assign keep = capture_en & sample.valid & in_window;
  assign last = capture_en & sample.valid & sample.frame_last;

  // Nothing left to write in this frame, trailer goes out directly
  assign trailer_now = trailer_pend | (last & ~keep & ~pending);

  always_comb begin
    trailer_word.trailer.tag          = trailer_tag;
    trailer_word.trailer.frame_number = frame_num;
    trailer_word.trailer.word_count   = word_cnt;
  end

  always_ff @(posedge clk100M) begin
    if (rst_command || frame_rst) begin
      pending      <= 1'b0;
      trailer_pend <= 1'b0;
      word_cnt     <= '0;
      frame_num    <= '0;
      wr_en        <= 1'b0;
      frame_done   <= 1'b0;
    end else begin
      wr_en      <= 1'b0;
      frame_done <= 1'b0;
      if (trailer_now) begin
        wr_en            <= 1'b1;
        frame_done       <= 1'b1;
        entry.is_trailer <= 1'b1;
        entry.word       <= trailer_word;
        trailer_pend     <= 1'b0;
        word_cnt         <= '0;
        frame_num        <= frame_num + 1'b1; // Wraps at 4096
      end else if (keep && !pending && !sample.frame_last) begin
        held    <= sample.sample;  // Wait for its partner
        pending <= 1'b1;
      end else if (keep || (last && pending)) begin
        // Full pair, or a lone half word flushed at frame end
        wr_en                   <= 1'b1;
        entry.is_trailer        <= 1'b0;
        entry.word.pixels.first <= pending ? held : sample.sample;
        entry.word.pixels.second <= (pending && keep) ? sample.sample : '0;
        word_cnt                <= word_cnt + 1'b1;
        pending                 <= 1'b0;
        trailer_pend            <= last;
      end
    end
  end

endmodule

/* hdl/event_fifo.sv */
`timescale 1ns/1ps

module event_fifo (
  input  logic                                  clk100M,
  input  logic                                  rst_command,
  input  logic                                  clear,
  input  logic                                  wr_en,
  input  readout_pkg::fifo_entry_t              wr_entry,
  input  logic                                  rd_en,
  output readout_pkg::fifo_entry_t              rd_entry,
  output logic                                  empty,
  output logic                                  full,
  output logic [readout_pkg::fifo_level_w-1:0] level
);
  import readout_pkg::*;

  fifo_entry_t            mem [fifo_depth];
  logic [fifo_addr_w-1:0] wr_ptr;
  logic [fifo_addr_w-1:0] rd_ptr;
  logic                   do_wr;
  logic                   do_rd;

  assign empty = level == '0;
  assign full  = level == fifo_level_w'(fifo_depth);
  assign do_wr = wr_en & ~full;   // Overflow data is lost
  assign do_rd = rd_en & ~empty;

  assign rd_entry = mem[rd_ptr];  // Head always on the output

  always_ff @(posedge clk100M) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_entry;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk100M) begin
    if (rst_command || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      level <= level + fifo_level_w'(do_wr) - fifo_level_w'(do_rd);
    end
  end

endmodule

/* hdl/readout_top.sv */
`timescale 1ns/1ps

module readout_top (
  input  logic                     clk100M,
  input  logic                     rst_command,
  input  readout_pkg::apb_req_t    apb_req,
  output readout_pkg::apb_rsp_t    apb_rsp,
  input  readout_pkg::adc_sample_t sample,
  input  logic                     rd_en,
  output readout_pkg::fifo_entry_t rd_data,
  output logic                     empty,
  output logic [7:0]               chip_addr
);
  import readout_pkg::*;

  wire run_cmd_t     cmd;
  wire read_window_t window;
  wire run_status_t  status;     // Fields driven by run_control and event_fifo
  wire               capture_en;
  wire               frame_rst;
  wire               fifo_clear;
  wire               frame_done;
  wire               wr_en;
  wire fifo_entry_t  wr_entry;

  cmd_regs u_cmd_regs (
    .clk100M     (clk100M),
    .rst_command (rst_command),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .status      (status),
    .cmd         (cmd),
    .window      (window),
    .chip_addr   (chip_addr)
  );

  run_control u_run_control (
    .clk100M     (clk100M),
    .rst_command (rst_command),
    .cmd         (cmd),
    .frame_done  (frame_done),
    .fifo_full   (status.fifo_full),
    .capture_en  (capture_en),
    .frame_rst   (frame_rst),
    .fifo_clear  (fifo_clear),
    .state       (status.state),
    .veto        (status.veto)
  );

  pixel_packer u_pixel_packer (
    .clk100M     (clk100M),
    .rst_command (rst_command),
    .frame_rst   (frame_rst),
    .capture_en  (capture_en),
    .sample      (sample),
    .window      (window),
    .wr_en       (wr_en),
    .entry       (wr_entry),
    .frame_done  (frame_done)
  );

  event_fifo u_event_fifo (
    .clk100M     (clk100M),
    .rst_command (rst_command),
    .clear       (fifo_clear),
    .wr_en       (wr_en),
    .wr_entry    (wr_entry),
    .rd_en       (rd_en),
    .rd_entry    (rd_data),
    .empty       (empty),
    .full        (status.fifo_full),
    .level       (status.fifo_level)
  );

endmodule

/* include/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Fibonacci LFSR step, taps 32 22 2 1, shifting left
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic report_fail(input string what);
  $display("MISMATCH %s", what);
  $display("Checks failed");
  $fatal(1);
endtask

task automatic check_entry(input string what, input readout_pkg::fifo_entry_t got,
                           input readout_pkg::fifo_entry_t exp);
  if (got !== exp) report_fail($sformatf("%s entry got %h exp %h", what, got, exp));
endtask

task automatic check_status(input string what, input readout_pkg::run_status_t got,
                            input readout_pkg::run_status_t exp);
  if (got !== exp) report_fail($sformatf("%s status got %h exp %h", what, got, exp));
endtask

task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) report_fail($sformatf("%s word got %h exp %h", what, got, exp));
endtask

`endif

/* bench/tb_readout.sv */
`timescale 1ns/1ps

module tb_readout;
  import readout_pkg::*;
  `include "tb_checks.svh"

  localparam int timeout_cycles = 2000; // Bound on every wait loop

  logic        clk100M;
  logic        rst_command;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  adc_sample_t sample;
  logic        rd_en;
  fifo_entry_t rd_data;
  logic        empty;
  logic [7:0]  chip_addr;

  logic [31:0]  lfsr_state;
  fifo_entry_t  exp_q[$];    // Entries the host should read next
  logic [15:0]  kept_q[$];   // Samples inside the window, current frame
  read_window_t cur_win;     // Window last written over APB
  int           frame_count; // Next trailer frame number

  readout_top DUT (
    .clk100M     (clk100M),
    .rst_command (rst_command),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .sample      (sample),
    .rd_en       (rd_en),
    .rd_data     (rd_data),
    .empty       (empty),
    .chip_addr   (chip_addr)
  );

  always #5 clk100M = ~clk100M; // 100 MHz

  // Takes nbits, one LFSR step per bit, LSB first
  function automatic logic [31:0] random_bits(input int nbits);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r[i] = lfsr_state[0];
    end
    return r;
  endfunction

  function automatic string stamp(input string name);
    return $sformatf("t=%0t %s", $time, name);
  endfunction

  task automatic abort_run(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic apb_access(input logic [3:0] addr, input logic write, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk100M); #1;
    apb_req.psel    = 1'b1;  // Setup phase
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk100M); #1;
    apb_req.penable = 1'b1;  // Access phase
    @(negedge clk100M);
    check_word(stamp("pready"), {31'd0, apb_rsp.pready}, 32'd1); // Zero wait states
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk100M); #1;  // Access ended at this edge
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    logic        err;
    apb_access(addr, 1'b1, data, unused, err);
    check_word(stamp("pslverr"), {31'd0, err}, 32'd0);
  endtask

  task automatic send_cmd(input int bit_idx);
    apb_write(addr_control, 32'd1 << bit_idx);
    if (bit_idx == ctl_init || bit_idx == ctl_soft_rst) frame_count = 0; // Numbering restarts
  endtask

  task automatic set_window(input read_window_t win);
    apb_write(addr_window, {12'd0, win});
    cur_win = win;
  endtask

  task automatic expect_status(input run_state_e st, input logic veto, input logic full,
                               input int level);
    logic [31:0] data;
    logic        err;
    run_status_t got;
    run_status_t exp;
    apb_access(addr_status, 1'b0, '0, data, err);
    got = data[$bits(run_status_t)-1:0];
    exp.state      = st;
    exp.veto       = veto;
    exp.fifo_full  = full;
    exp.fifo_level = 7'(level);
    check_status(stamp("status"), got, exp);
  endtask

  task automatic wait_veto_clear();
    logic [31:0] data;
    logic        err;
    run_status_t st;
    int          polls;
    polls = 0;
    apb_access(addr_status, 1'b0, '0, data, err);
    st = data[$bits(run_status_t)-1:0];
    while (st.veto) begin
      if (polls >= timeout_cycles) abort_run("timed out waiting for veto to clear");
      apb_access(addr_status, 1'b0, '0, data, err);
      st = data[$bits(run_status_t)-1:0];
      polls++;
    end
  endtask

  // One valid cycle, then one idle cycle
  task automatic drive_sample(input logic [5:0] row, input logic [3:0] col,
                              input logic [15:0] value, input logic last);
    @(posedge clk100M); #1;
    sample.valid      = 1'b1;
    sample.row        = row;
    sample.col        = col;
    sample.sample     = value;
    sample.frame_last = last;
    @(posedge clk100M); #1;
    sample.valid      = 1'b0;
    sample.frame_last = 1'b0;
  endtask

  function automatic bit in_window(input read_window_t w, input int row, input int col);
    return row >= int'(w.row_start) && row <= int'(w.row_end) &&
           col >= int'(w.col_start) && col <= int'(w.col_end);
  endfunction

  // Pairs in arrival order, then the trailer
  task automatic expect_frame();
    fifo_entry_t e;
    int          words;
    words = 0;
    for (int i = 0; i < kept_q.size(); i += 2) begin
      e = '0;
      e.word.pixels.first = kept_q[i];
      if (i + 1 < kept_q.size()) e.word.pixels.second = kept_q[i + 1]; // Odd count, zero high
      exp_q.push_back(e);
      words++;
    end
    e = '0;
    e.is_trailer                = 1'b1;
    e.word.trailer.tag          = 8'hFE;
    e.word.trailer.frame_number = 12'(frame_count);
    e.word.trailer.word_count   = 12'(words);
    exp_q.push_back(e);
    frame_count++;
  endtask

  // 8x8 frame in row order, optional stop command before sample stop_at
  task automatic feed_frame(input int stop_at, input bit captured);
    logic [15:0] value;
    int          idx;
    kept_q.delete();
    for (int r = 0; r < 8; r++) begin
      for (int c = 0; c < 8; c++) begin
        idx = r * 8 + c;
        if (idx == stop_at) send_cmd(ctl_stop);
        value = 16'(random_bits(16));
        if (captured && in_window(cur_win, r, c)) kept_q.push_back(value);
        drive_sample(6'(r), 4'(c), value, idx == 63);
      end
    end
    if (captured) expect_frame();
  endtask

  task automatic pop_entry(output fifo_entry_t e);
    int waited;
    waited = 0;
    @(posedge clk100M); #1;
    while (empty) begin
      if (waited >= timeout_cycles) abort_run("timed out waiting for a FIFO entry");
      @(posedge clk100M); #1;
      waited++;
    end
    e     = rd_data;  // Head is valid while empty is low
    rd_en = 1'b1;
    @(posedge clk100M); #1;
    rd_en = 1'b0;
  endtask

  task automatic drain_entries(input int n);
    fifo_entry_t got;
    fifo_entry_t exp;
    for (int i = 0; i < n; i++) begin
      if (exp_q.size() == 0) abort_run("no expected entry left to compare");
      pop_entry(got);
      exp = exp_q.pop_front();
      check_entry(stamp("rd_data"), got, exp);
    end
  endtask

  task automatic test_registers();
    read_window_t win;
    logic [31:0]  data;
    logic         err;
    check_word(stamp("chip_addr"), {24'd0, chip_addr}, 32'd0);
    check_word(stamp("empty"), {31'd0, empty}, 32'd1);
    win = '{row_start: 6'd3, row_end: 6'd40, col_start: 4'd1, col_end: 4'd9};
    set_window(win);
    apb_access(addr_window, 1'b0, '0, data, err);
    check_word(stamp("window"), data, {12'd0, win});
    apb_write(addr_chip, 32'h0000_005A);
    apb_access(addr_chip, 1'b0, '0, data, err);
    check_word(stamp("chip_reg"), data, 32'h0000_005A);
    check_word(stamp("chip_addr"), {24'd0, chip_addr}, 32'd0); // Not sent yet
    apb_access(4'h6, 1'b0, '0, data, err);
    check_word(stamp("pslverr"), {31'd0, err}, 32'd1);
    apb_access(4'hD, 1'b0, '0, data, err);
    check_word(stamp("pslverr"), {31'd0, err}, 32'd1);
    send_cmd(ctl_init);
    check_word(stamp("chip_addr"), {24'd0, chip_addr}, 32'd0);
    @(posedge clk100M); #1;
    check_word(stamp("chip_addr"), {24'd0, chip_addr}, 32'h0000_005A);
  endtask

  task automatic test_settling_veto();
    set_window('{row_start: 6'd0, row_end: 6'd7, col_start: 4'd0, col_end: 4'd7});
    send_cmd(ctl_soft_rst);           // Restart the settling count
    expect_status(st_idle, 1'b1, 1'b0, 0);
    send_cmd(ctl_init);
    send_cmd(ctl_start);
    for (int i = 0; i < 180; i++) begin // About 360 cycles, well inside the hold
      drive_sample(6'((i / 8) % 8), 4'(i % 8), 16'(random_bits(16)), (i % 64) == 63);
    end
    expect_status(st_running, 1'b1, 1'b0, 0);
    wait_veto_clear();
    expect_status(st_running, 1'b0, 1'b0, 0);
  endtask

  task automatic test_packing();
    set_window('{row_start: 6'd1, row_end: 6'd3, col_start: 4'd2, col_end: 4'd6}); // 15 kept
    feed_frame(-1, 1'b1);
    drain_entries(exp_q.size());
    set_window('{row_start: 6'd2, row_end: 6'd5, col_start: 4'd0, col_end: 4'd5}); // 24 kept
    feed_frame(-1, 1'b1);
    drain_entries(exp_q.size());
    check_word(stamp("empty"), {31'd0, empty}, 32'd1);
  endtask

  task automatic test_stop();
    set_window('{row_start: 6'd0, row_end: 6'd7, col_start: 4'd3, col_end: 4'd4});
    feed_frame(30, 1'b1);             // Stop lands mid frame
    drain_entries(exp_q.size());
    feed_frame(-1, 1'b0);             // Idle, nothing captured
    expect_status(st_idle, 1'b0, 1'b0, 0);
    check_word(stamp("empty"), {31'd0, empty}, 32'd1);
  endtask

  task automatic test_overflow();
    fifo_entry_t exp;
    set_window('{row_start: 6'd0, row_end: 6'd7, col_start: 4'd0, col_end: 4'd7});
    send_cmd(ctl_init);
    send_cmd(ctl_start);
    feed_frame(-1, 1'b1);             // 33 entries
    feed_frame(-1, 1'b1);             // Only 31 more fit
    expect_status(st_running, 1'b1, 1'b1, 64);
    drain_entries(63);
    @(posedge clk100M); #1;
    if (empty) abort_run("FIFO empty before its 64th entry");
    exp = exp_q.pop_front();
    check_entry(stamp("rd_data"), rd_data, exp); // Last kept entry, left in place
    exp_q.delete();
    send_cmd(ctl_soft_rst);
    @(posedge clk100M); #1;
    check_word(stamp("empty"), {31'd0, empty}, 32'd1);
    expect_status(st_idle, 1'b1, 1'b0, 0);
    wait_veto_clear();
    send_cmd(ctl_init);
    send_cmd(ctl_start);
    feed_frame(-1, 1'b1);
    drain_entries(exp_q.size());
    check_word(stamp("empty"), {31'd0, empty}, 32'd1);
  endtask

  initial begin
    clk100M     = 1'b0;
    rst_command = 1'b1;
    apb_req     = '0;
    sample      = '0;
    rd_en       = 1'b0;
    lfsr_state  = 32'h60647d63;
    frame_count = 0;
    cur_win     = '0;
    repeat (5) @(posedge clk100M);
    #1;
    rst_command = 1'b0;
    expect_status(st_idle, 1'b1, 1'b0, 0); // Veto up after reset
    test_registers();
    test_settling_veto();
    test_packing();
    test_stop();
    test_overflow();
    $display("All checks passed");
    $finish;
  end

endmodule

/* all.f */
+incdir+include
hdl/readout_pkg.sv
hdl/cmd_regs.sv
hdl/run_control.sv
hdl/pixel_packer.sv
hdl/event_fifo.sv
hdl/readout_top.sv
bench/tb_readout.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the readout testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_readout \
  -Mdir obj_dir -o sim_readout
./obj_dir/sim_readout
